// File: common/mips_pkg.sv
package mips_pkg;

	localparam int XLEN   = 32; // data and address width
	localparam int REG_AW = 5;

	typedef logic [REG_AW-1:0] reg_addr_t;

	// register-format fields, msb first
	typedef struct packed {
		logic [5:0] op;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] sa;
		logic [5:0] func;
	} r_form_t;

	// immediate format, rs/rt/imm16 also carry the jump target
	typedef struct packed {
		logic [5:0]  op;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm16;
	} i_form_t;

	typedef union packed {
		r_form_t r;
		i_form_t i;
	} instr_u;

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// func field under SPECIAL
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	typedef enum logic [3:0] {
		ALU_AND, ALU_OR, ALU_ADD, ALU_SUB,
		ALU_SLT, ALU_SLTU, ALU_NOR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] operand_a;
		logic [XLEN-1:0] operand_b;
		logic [XLEN-1:0] store_data; // rt value for SW
		alu_op_e         alu_op;
		logic            mem_en;
		logic            mem_we;
		logic            reg_we;
		reg_addr_t       waddr;
		logic            is_load;
	} dec_exe_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] alu_result;
		logic            reg_we;
		reg_addr_t       waddr;
		logic            is_load;
	} exe_res_t;

	// one bypass source seen by decode
	typedef struct packed {
		logic            valid;
		logic            reg_we;
		logic            is_load;
		reg_addr_t       waddr;
		logic [XLEN-1:0] wdata;
	} fwd_t;

endpackage

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  reg_addr_t       raddr1,
	input  reg_addr_t       raddr2,
	input  reg_addr_t       waddr,
	input  logic            we,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2
);

	logic [XLEN-1:0] regs [32];

	// entry 0 cleared on reset and never written again
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// plain read, same-cycle write shows up next cycle
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_e         op,
	output logic [XLEN-1:0] result
);

	logic [XLEN-1:0] diff;
	logic            lt_signed;
	logic            lt_unsigned;
	logic [4:0]      shamt;

	assign diff        = a - b;
	assign shamt       = b[4:0]; // shifts move a, count in b
	// signs differ -> a negative means smaller, else look at the difference
	assign lt_signed   = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : diff[XLEN-1];
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = diff;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_NOR:  result = ~(a | b);
			ALU_XOR:  result = a ^ b;
			ALU_SLL:  result = a << shamt;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt; // sign fill
			ALU_LUI:  result = {b[15:0], 16'h0000};
			default:  result = a + b;
		endcase
	end

endmodule

// File: core/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'hbfc00000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [XLEN-1:0] inst_rdata,
	input  logic [XLEN-1:0] rdata1,
	input  logic [XLEN-1:0] rdata2,
	input  fwd_t            exe_fwd,
	input  fwd_t            mem_fwd,
	input  fwd_t            wb_fwd,
	output logic [XLEN-1:0] inst_addr,
	output reg_addr_t       raddr1,
	output reg_addr_t       raddr2,
	output dec_exe_t        dec_out,
	output logic            dec_valid
);

	logic [XLEN-1:0] pc;        // address sent last cycle, its word is on inst_rdata
	logic            fetch_vld; // inst_rdata holds a real fetch
	logic [XLEN-1:0] dec_pc;
	instr_u          dec_ins;
	logic            dec_vld;
	logic            stall;
	logic [XLEN-1:0] rs_val;
	logic [XLEN-1:0] rt_val;
	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_zext;
	logic [XLEN-1:0] sa_ext;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] next_pc;
	logic            is_special;
	logic            is_shift;
	logic            is_jr;
	logic            is_j;
	logic            take_br;

	function automatic logic fwd_hit(fwd_t f, reg_addr_t r);
		return f.valid && f.reg_we && !f.is_load && f.waddr == r && r != '0;
	endfunction

	// newest producer wins
	function automatic logic [XLEN-1:0] fwd_val(fwd_t e, fwd_t m, fwd_t w, reg_addr_t r,
			logic [XLEN-1:0] rf_val);
		if (fwd_hit(e, r))
			return e.wdata;
		else if (fwd_hit(m, r))
			return m.wdata;
		else if (fwd_hit(w, r))
			return w.wdata;
		return rf_val;
	endfunction

	function automatic logic load_hit(fwd_t f, reg_addr_t a, reg_addr_t b);
		return f.valid && f.is_load && (f.waddr == a || f.waddr == b);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			pc        <= RESET_PC;
			fetch_vld <= 1'b0;
			dec_vld   <= 1'b0;
		end else begin
			fetch_vld <= 1'b1;
			if (!stall) begin
				dec_vld <= fetch_vld;
				if (fetch_vld)
					pc <= next_pc;
			end
		end
	end

	// decode payload, held through a stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			dec_pc  <= pc;
			dec_ins <= inst_rdata;
		end
	end

	assign raddr1   = dec_ins.r.rs;
	assign raddr2   = dec_ins.r.rt;
	assign rs_val   = fwd_val(exe_fwd, mem_fwd, wb_fwd, dec_ins.r.rs, rdata1);
	assign rt_val   = fwd_val(exe_fwd, mem_fwd, wb_fwd, dec_ins.r.rt, rdata2);
	assign imm_sext = {{16{dec_ins.i.imm16[15]}}, dec_ins.i.imm16};
	assign imm_zext = {16'h0000, dec_ins.i.imm16};
	assign sa_ext   = {{(XLEN-5){1'b0}}, dec_ins.r.sa};
	assign pc_plus4 = dec_pc + XLEN'(4); // delay slot address

	assign is_special = dec_ins.r.op == OP_SPECIAL;
	assign is_shift   = is_special && dec_ins.r.func inside {FN_SLL, FN_SRL, FN_SRA};
	assign is_jr      = is_special && dec_ins.r.func == FN_JR;
	assign is_j       = dec_ins.i.op == OP_J;
	assign take_br    = (dec_ins.i.op == OP_BEQ && rs_val == rt_val) ||
		(dec_ins.i.op == OP_BNE && rs_val != rt_val);

	// load still in flight for rs or rt, wait until it reaches the regfile
	assign stall = dec_vld && (load_hit(exe_fwd, dec_ins.r.rs, dec_ins.r.rt) ||
		load_hit(mem_fwd, dec_ins.r.rs, dec_ins.r.rt) ||
		load_hit(wb_fwd, dec_ins.r.rs, dec_ins.r.rt));

	assign dec_valid = dec_vld && !stall;

	// fetch already has the delay slot, so redirect the one after it
	always_comb begin
		next_pc = pc + XLEN'(4);
		if (dec_vld) begin
			if (is_j)
				next_pc = {pc_plus4[XLEN-1:28], dec_ins.i.rs, dec_ins.i.rt,
					dec_ins.i.imm16, 2'b00};
			else if (is_jr)
				next_pc = rs_val;
			else if (take_br)
				next_pc = pc_plus4 + {imm_sext[XLEN-3:0], 2'b00};
		end
	end

	assign inst_addr = (fetch_vld && !stall) ? next_pc : pc; // replay word on stall

	always_comb begin
		dec_out            = '0;
		dec_out.pc         = dec_pc;
		dec_out.operand_a  = rs_val;
		dec_out.operand_b  = imm_sext;
		dec_out.store_data = rt_val;
		dec_out.alu_op     = ALU_ADD;
		dec_out.waddr      = dec_ins.i.rt; // immediate forms write rt
		case (dec_ins.r.op)
			OP_SPECIAL: begin
				dec_out.operand_b = rt_val;
				dec_out.waddr     = dec_ins.r.rd;
				dec_out.reg_we    = 1'b1;
				case (dec_ins.r.func)
					FN_ADDU: dec_out.alu_op = ALU_ADD;
					FN_SUBU: dec_out.alu_op = ALU_SUB;
					FN_AND:  dec_out.alu_op = ALU_AND;
					FN_OR:   dec_out.alu_op = ALU_OR;
					FN_XOR:  dec_out.alu_op = ALU_XOR;
					FN_NOR:  dec_out.alu_op = ALU_NOR;
					FN_SLT:  dec_out.alu_op = ALU_SLT;
					FN_SLTU: dec_out.alu_op = ALU_SLTU;
					FN_SLL:  dec_out.alu_op = ALU_SLL;
					FN_SRL:  dec_out.alu_op = ALU_SRL;
					FN_SRA:  dec_out.alu_op = ALU_SRA;
					default: dec_out.reg_we = 1'b0; // JR and anything unknown
				endcase
				if (is_shift) begin
					dec_out.operand_a = rt_val; // value to shift
					dec_out.operand_b = sa_ext;
				end
			end
			OP_ADDIU: dec_out.reg_we = 1'b1;
			OP_SLTI: begin
				dec_out.alu_op = ALU_SLT;
				dec_out.reg_we = 1'b1;
			end
			OP_SLTIU: begin
				dec_out.alu_op = ALU_SLTU; // sign-extended imm, unsigned compare
				dec_out.reg_we = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				dec_out.operand_b = imm_zext;
				dec_out.reg_we    = 1'b1;
				case (dec_ins.i.op)
					OP_ANDI: dec_out.alu_op = ALU_AND;
					OP_ORI:  dec_out.alu_op = ALU_OR;
					OP_XORI: dec_out.alu_op = ALU_XOR;
					default: dec_out.alu_op = ALU_LUI;
				endcase
			end
			OP_LW: begin
				dec_out.mem_en  = 1'b1;
				dec_out.reg_we  = 1'b1;
				dec_out.is_load = 1'b1;
			end
			OP_SW: begin
				dec_out.mem_en = 1'b1;
				dec_out.mem_we = 1'b1;
			end
			default: ; // branches, J, unknown
		endcase
	end

endmodule

// File: core/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  dec_exe_t        dec_in,
	input  logic            dec_valid,
	output exe_res_t        exe_out,
	output logic            exe_valid,
	output fwd_t            exe_fwd,
	output logic            data_sram_en,
	output logic [3:0]      data_sram_wen,
	output logic [XLEN-1:0] data_sram_addr,
	output logic [XLEN-1:0] data_sram_wdata
);

	dec_exe_t        ex_q;
	logic            ex_vld;
	logic [XLEN-1:0] alu_result;

	always_ff @(posedge clk) begin
		if (rst)
			ex_vld <= 1'b0;
		else
			ex_vld <= dec_valid;
	end

	// nothing downstream ever stalls, so load every cycle
	always_ff @(posedge clk) begin
		ex_q <= dec_in;
	end

	alu u_alu (
		.a      (ex_q.operand_a),
		.b      (ex_q.operand_b),
		.op     (ex_q.alu_op),
		.result (alu_result)
	);

	// address is rs + offset from the adder
	assign data_sram_en    = ex_vld && ex_q.mem_en;
	assign data_sram_wen   = {4{ex_vld && ex_q.mem_we}}; // word stores only
	assign data_sram_addr  = alu_result;
	assign data_sram_wdata = ex_q.store_data;

	assign exe_valid = ex_vld;
	assign exe_out   = '{
		pc:         ex_q.pc,
		alu_result: alu_result,
		reg_we:     ex_q.reg_we,
		waddr:      ex_q.waddr,
		is_load:    ex_q.is_load
	};

	// load result not known yet, decode sees is_load and waits
	assign exe_fwd = '{
		valid:   ex_vld,
		reg_we:  ex_q.reg_we,
		is_load: ex_q.is_load,
		waddr:   ex_q.waddr,
		wdata:   alu_result
	};

endmodule

// File: core/result_stage.sv
`timescale 1ns/1ps

module result_stage import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  exe_res_t        exe_in,
	input  logic            exe_valid,
	input  logic [XLEN-1:0] data_sram_rdata,
	output fwd_t            mem_fwd,
	output fwd_t            wb_fwd,
	output logic            rf_we,
	output reg_addr_t       rf_waddr,
	output logic [XLEN-1:0] rf_wdata,
	output logic [XLEN-1:0] debug_wb_pc,
	output logic [3:0]      debug_wb_rf_wen,
	output reg_addr_t       debug_wb_rf_wnum,
	output logic [XLEN-1:0] debug_wb_rf_wdata
);

	exe_res_t        mem_q;
	exe_res_t        wb_q;      // alu_result here is the final write data
	logic            mem_vld;
	logic            wb_vld;
	logic [XLEN-1:0] mem_wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_vld <= 1'b0;
			wb_vld  <= 1'b0;
		end else begin
			mem_vld <= exe_valid;
			wb_vld  <= mem_vld;
		end
	end

	// sram word arrives while the load sits here
	assign mem_wdata = mem_q.is_load ? data_sram_rdata : mem_q.alu_result;

	always_ff @(posedge clk) begin
		mem_q <= exe_in;
		wb_q  <= '{
			pc:         mem_q.pc,
			alu_result: mem_wdata,
			reg_we:     mem_q.reg_we,
			waddr:      mem_q.waddr,
			is_load:    mem_q.is_load
		};
	end

	assign mem_fwd = '{
		valid:   mem_vld,
		reg_we:  mem_q.reg_we,
		is_load: mem_q.is_load,
		waddr:   mem_q.waddr,
		wdata:   mem_q.alu_result
	};
	// loads stay flagged here too, regfile write lands at the end of this cycle
	assign wb_fwd = '{
		valid:   wb_vld,
		reg_we:  wb_q.reg_we,
		is_load: wb_q.is_load,
		waddr:   wb_q.waddr,
		wdata:   wb_q.alu_result
	};

	assign rf_we             = wb_vld && wb_q.reg_we;
	assign rf_waddr          = wb_q.waddr;
	assign rf_wdata          = wb_q.alu_result;
	assign debug_wb_pc       = wb_q.pc;
	assign debug_wb_rf_wen   = {4{rf_we}};
	assign debug_wb_rf_wnum  = wb_q.waddr;
	assign debug_wb_rf_wdata = wb_q.alu_result;

endmodule

// File: core/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'hbfc00000
) (
	input  logic            clk,
	input  logic            rst,
	output logic            inst_sram_en,
	output logic [3:0]      inst_sram_wen,
	output logic [XLEN-1:0] inst_sram_addr,
	output logic [XLEN-1:0] inst_sram_wdata,
	input  logic [XLEN-1:0] inst_sram_rdata,
	output logic            data_sram_en,
	output logic [3:0]      data_sram_wen,
	output logic [XLEN-1:0] data_sram_addr,
	output logic [XLEN-1:0] data_sram_wdata,
	input  logic [XLEN-1:0] data_sram_rdata,
	output logic [XLEN-1:0] debug_wb_pc,
	output logic [3:0]      debug_wb_rf_wen,
	output reg_addr_t       debug_wb_rf_wnum,
	output logic [XLEN-1:0] debug_wb_rf_wdata
);

	dec_exe_t        dec_bus;
	logic            dec_valid;
	exe_res_t        exe_bus;
	logic            exe_valid;
	fwd_t            exe_fwd;
	fwd_t            mem_fwd;
	fwd_t            wb_fwd;
	reg_addr_t       raddr1;
	reg_addr_t       raddr2;
	reg_addr_t       rf_waddr;
	logic            rf_we;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	logic [XLEN-1:0] rf_wdata;

	// instruction port is read-only
	assign inst_sram_en    = 1'b1;
	assign inst_sram_wen   = 4'b0000;
	assign inst_sram_wdata = '0;

	decode_stage #(
		.RESET_PC (RESET_PC)
	) u_decode (
		.clk        (clk),
		.rst        (rst),
		.inst_rdata (inst_sram_rdata),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.exe_fwd    (exe_fwd),
		.mem_fwd    (mem_fwd),
		.wb_fwd     (wb_fwd),
		.inst_addr  (inst_sram_addr),
		.raddr1     (raddr1),
		.raddr2     (raddr2),
		.dec_out    (dec_bus),
		.dec_valid  (dec_valid)
	);

	execute_stage u_execute (
		.clk             (clk),
		.rst             (rst),
		.dec_in          (dec_bus),
		.dec_valid       (dec_valid),
		.exe_out         (exe_bus),
		.exe_valid       (exe_valid),
		.exe_fwd         (exe_fwd),
		.data_sram_en    (data_sram_en),
		.data_sram_wen   (data_sram_wen),
		.data_sram_addr  (data_sram_addr),
		.data_sram_wdata (data_sram_wdata)
	);

	result_stage u_result (
		.clk               (clk),
		.rst               (rst),
		.exe_in            (exe_bus),
		.exe_valid         (exe_valid),
		.data_sram_rdata   (data_sram_rdata),
		.mem_fwd           (mem_fwd),
		.wb_fwd            (wb_fwd),
		.rf_we             (rf_we),
		.rf_waddr          (rf_waddr),
		.rf_wdata          (rf_wdata),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	regfile u_regfile (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.waddr  (rf_waddr),
		.we     (rf_we),
		.wdata  (rf_wdata),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

endmodule

// File: verif/tb_tasks.svh
// R-type word, shifts put the value in rt and rs at zero
function automatic logic [XLEN-1:0] r_ins(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
		reg_addr_t rt, logic [4:0] sa);
	return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic logic [XLEN-1:0] i_ins(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
		logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [XLEN-1:0] sext16(logic [15:0] imm);
	return {{16{imm[15]}}, imm};
endfunction

function automatic void place_instr(logic [XLEN-1:0] word);
	imem[prog_len] = word; // word k sits at RESET_PC + 4k
	prog_len++;
endfunction

// places an instruction and queues the write it must retire with
function automatic void add_writer(logic [XLEN-1:0] word, reg_addr_t rd,
		logic [XLEN-1:0] value);
	retire_t rec;
	place_instr(word);
	rec.pc    = RESET_PC + XLEN'(4 * (prog_len - 1));
	rec.rnum  = rd;
	rec.value = value; // debug port shows the result even for r0
	expected_q.push_back(rec);
	if (rd != '0)
		gpr[rd] = value;
endfunction

task automatic check_retire(input logic [XLEN-1:0] pc, input reg_addr_t rnum,
		input logic [XLEN-1:0] value);
	if (debug_wb_pc !== pc)
		abort_run($sformatf("Error: debug_wb_pc got %h, expected %h", debug_wb_pc, pc));
	if (debug_wb_rf_wen !== 4'hf)
		abort_run($sformatf("Error: debug_wb_rf_wen got %h, expected f", debug_wb_rf_wen));
	if (debug_wb_rf_wnum !== rnum)
		abort_run($sformatf("Error: debug_wb_rf_wnum got %h, expected %h",
			debug_wb_rf_wnum, rnum));
	if (debug_wb_rf_wdata !== value)
		abort_run($sformatf("Error: debug_wb_rf_wdata got %h, expected %h",
			debug_wb_rf_wdata, value));
endtask

task automatic check_mem(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] value);
	if (dmem[addr[9:2]] !== value)
		abort_run($sformatf("Error: dmem[%h] got %h, expected %h", addr, dmem[addr[9:2]],
			value));
endtask

// fixed port values, looked at every cycle of a run
task automatic check_sram_ports;
	if (inst_sram_en !== 1'b1)
		abort_run($sformatf("Error: inst_sram_en got %h, expected 1", inst_sram_en));
	if (inst_sram_wen !== 4'h0)
		abort_run($sformatf("Error: inst_sram_wen got %h, expected 0", inst_sram_wen));
	if (inst_sram_wdata !== '0)
		abort_run($sformatf("Error: inst_sram_wdata got %h, expected 0",
			inst_sram_wdata));
	if (data_sram_wen !== 4'h0 && data_sram_wen !== 4'hf) // word stores only
		abort_run($sformatf("Error: data_sram_wen got %h, expected 0 or f",
			data_sram_wen));
endtask

// holds the core in reset while the new program goes in
task automatic start_program;
	@(posedge clk);
	rst <= 1'b1;
	@(negedge clk); // memories are quiet here
	expected_q.delete();
	prog_len = 0;
	for (int k = 0; k < 256; k++) begin
		imem[k] = '0; // nop
		dmem[k] = '0;
	end
	for (int k = 0; k < 32; k++)
		gpr[k] = '0;
endtask

// release reset, then match every debug write in order
task automatic run_program;
	repeat (2) @(posedge clk);
	rst <= 1'b0;
	foreach (expected_q[k]) begin
		@(negedge clk);
		check_sram_ports();
		while (debug_wb_rf_wen == 4'h0) begin
			@(negedge clk);
			check_sram_ports();
		end
		check_retire(expected_q[k].pc, expected_q[k].rnum, expected_q[k].value);
	end
endtask

task automatic test_alu;
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [15:0]     imm;
	logic [4:0]      sa;
	a   = $urandom;
	b   = $urandom;
	imm = 16'($urandom);
	sa  = 5'($urandom);
	start_program();
	add_writer(i_ins(OP_LUI, 1, 0, a[31:16]), 1, {a[31:16], 16'h0000});
	add_writer(i_ins(OP_ORI, 1, 1, a[15:0]), 1, a);
	add_writer(i_ins(OP_LUI, 2, 0, b[31:16]), 2, {b[31:16], 16'h0000});
	add_writer(i_ins(OP_ORI, 2, 2, b[15:0]), 2, b);
	add_writer(r_ins(FN_ADDU, 3, 1, 2, 0), 3, a + b);
	add_writer(r_ins(FN_SUBU, 4, 1, 2, 0), 4, a - b);
	add_writer(r_ins(FN_AND, 5, 1, 2, 0), 5, a & b);
	add_writer(r_ins(FN_OR, 6, 1, 2, 0), 6, a | b);
	add_writer(r_ins(FN_XOR, 7, 1, 2, 0), 7, a ^ b);
	add_writer(r_ins(FN_NOR, 8, 1, 2, 0), 8, ~(a | b));
	add_writer(r_ins(FN_SLT, 9, 1, 2, 0), 9, 32'($signed(a) < $signed(b)));
	add_writer(r_ins(FN_SLTU, 10, 1, 2, 0), 10, 32'(a < b));
	add_writer(r_ins(FN_SLL, 11, 0, 2, sa), 11, b << sa);
	add_writer(r_ins(FN_SRL, 12, 0, 2, sa), 12, b >> sa);
	add_writer(r_ins(FN_SRA, 13, 0, 2, sa), 13, $signed(b) >>> sa); // sign fill
	add_writer(i_ins(OP_ADDIU, 14, 1, imm), 14, a + sext16(imm));
	add_writer(i_ins(OP_ANDI, 15, 1, imm), 15, a & {16'h0000, imm}); // zero extended
	add_writer(i_ins(OP_ORI, 16, 1, imm), 16, a | {16'h0000, imm});
	add_writer(i_ins(OP_XORI, 17, 1, imm), 17, a ^ {16'h0000, imm});
	add_writer(i_ins(OP_SLTI, 18, 1, imm), 18, 32'($signed(a) < $signed(sext16(imm))));
	add_writer(i_ins(OP_SLTIU, 19, 1, imm), 19, 32'(a < sext16(imm)));
	add_writer(i_ins(OP_LUI, 20, 0, imm), 20, {imm, 16'h0000});
	run_program();
endtask

task automatic test_forwarding;
	logic [XLEN-1:0] c;
	c = $urandom;
	start_program();
	add_writer(i_ins(OP_LUI, 1, 0, c[31:16]), 1, {c[31:16], 16'h0000});
	add_writer(i_ins(OP_ORI, 1, 1, c[15:0]), 1, c);
	add_writer(r_ins(FN_ADDU, 2, 1, 1, 0), 2, gpr[1] + gpr[1]); // both from execute
	add_writer(r_ins(FN_SUBU, 3, 2, 1, 0), 3, gpr[2] - gpr[1]); // distance 1 and 2
	add_writer(r_ins(FN_XOR, 4, 3, 1, 0), 4, gpr[3] ^ gpr[1]);  // distance 1 and 3
	add_writer(i_ins(OP_ADDIU, 5, 4, 16'h8001), 5, gpr[4] + 32'hffff8001);
	add_writer(r_ins(FN_OR, 6, 3, 2, 0), 6, gpr[3] | gpr[2]);   // writeback, regfile
	add_writer(r_ins(FN_SLTU, 7, 5, 6, 0), 7, 32'(gpr[5] < gpr[6]));
	add_writer(r_ins(FN_NOR, 8, 7, 4, 0), 8, ~(gpr[7] | gpr[4]));
	add_writer(r_ins(FN_SLL, 9, 0, 8, 3), 9, gpr[8] << 3);
	run_program();
endtask

task automatic test_memory;
	logic [XLEN-1:0] v;
	v = $urandom;
	start_program();
	add_writer(i_ins(OP_ORI, 1, 0, 16'h0100), 1, 32'h0000_0100); // base
	add_writer(i_ins(OP_LUI, 2, 0, v[31:16]), 2, {v[31:16], 16'h0000});
	add_writer(i_ins(OP_ORI, 2, 2, v[15:0]), 2, v);
	place_instr(i_ins(OP_SW, 2, 1, 16'h0008));
	add_writer(i_ins(OP_LW, 3, 1, 16'h0008), 3, v);
	add_writer(r_ins(FN_ADDU, 4, 3, 3, 0), 4, v + v); // load use at distance 1
	place_instr(i_ins(OP_SW, 4, 1, 16'h000c));
	add_writer(i_ins(OP_LW, 5, 1, 16'h000c), 5, v + v);
	add_writer(r_ins(FN_SUBU, 6, 5, 2, 0), 6, v);
	add_writer(i_ins(OP_LW, 7, 1, 16'h0008), 7, v);
	add_writer(i_ins(OP_ORI, 8, 0, 16'h0001), 8, 32'h1);
	add_writer(r_ins(FN_ADDU, 9, 7, 8, 0), 9, v + 32'h1); // load at distance 2
	run_program();
	check_mem(32'h0000_0108, v);
	check_mem(32'h0000_010c, v + v);
endtask

// offset 2 skips one word after the delay slot
task automatic test_branches;
	start_program();
	add_writer(i_ins(OP_ORI, 1, 0, 16'h0005), 1, 32'h5);
	add_writer(i_ins(OP_ORI, 2, 0, 16'h0005), 2, 32'h5);
	place_instr(i_ins(OP_BEQ, 2, 1, 16'h0002)); // taken, rt from execute
	add_writer(i_ins(OP_ADDIU, 3, 0, 16'h0001), 3, 32'h1);
	place_instr(i_ins(OP_ADDIU, 4, 0, 16'h0bad));
	place_instr(i_ins(OP_BNE, 2, 1, 16'h0002)); // not taken
	add_writer(i_ins(OP_ADDIU, 5, 0, 16'h0002), 5, 32'h2);
	add_writer(i_ins(OP_ADDIU, 6, 0, 16'h0003), 6, 32'h3);
	place_instr(i_ins(OP_BNE, 3, 1, 16'h0002)); // taken
	add_writer(i_ins(OP_ADDIU, 7, 0, 16'h0004), 7, 32'h4);
	place_instr(i_ins(OP_ADDIU, 8, 0, 16'h0bad));
	place_instr(i_ins(OP_BEQ, 3, 1, 16'h0002)); // not taken
	add_writer(i_ins(OP_ADDIU, 9, 0, 16'h0006), 9, 32'h6);
	add_writer(i_ins(OP_ADDIU, 10, 0, 16'h0007), 10, 32'h7);
	run_program();
endtask

task automatic test_jumps;
	logic [XLEN-1:0] jr_target;
	logic [XLEN-1:0] j_target;
	jr_target = RESET_PC + 32'd32; // word 8
	j_target  = RESET_PC + 32'd20; // word 5
	start_program();
	add_writer(i_ins(OP_LUI, 1, 0, jr_target[31:16]), 1, {jr_target[31:16], 16'h0000});
	add_writer(i_ins(OP_ORI, 1, 1, jr_target[15:0]), 1, jr_target);
	place_instr({OP_J, j_target[27:2]}); // same 256 MB region
	add_writer(i_ins(OP_ADDIU, 2, 0, 16'h0011), 2, 32'h11);
	place_instr(i_ins(OP_ADDIU, 3, 0, 16'h0bad));
	place_instr(r_ins(FN_JR, 0, 1, 0, 0));
	add_writer(i_ins(OP_ADDIU, 0, 0, 16'h0055), 0, 32'h55); // delay slot hits r0
	place_instr(i_ins(OP_ADDIU, 4, 0, 16'h0bad));
	add_writer(r_ins(FN_ADDU, 5, 0, 2, 0), 5, gpr[0] + gpr[2]);
	add_writer(i_ins(OP_ADDIU, 0, 0, 16'h0066), 0, 32'h66);
	add_writer(r_ins(FN_OR, 6, 0, 0, 0), 6, gpr[0] | gpr[0]); // r0 still zero
	run_program();
endtask

// File: verif/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

	localparam logic [XLEN-1:0] RESET_PC = 32'hbfc00000;
	localparam int TOTAL_INSTR      = 69; // sum over all five programs
	localparam int CYCLES_PER_INSTR = 20;

	// one expected debug port write
	typedef struct packed {
		logic [XLEN-1:0] pc;
		reg_addr_t       rnum;
		logic [XLEN-1:0] value;
	} retire_t;

	logic            clk;
	logic            rst;
	logic            inst_sram_en;
	logic [3:0]      inst_sram_wen;
	logic [XLEN-1:0] inst_sram_addr;
	logic [XLEN-1:0] inst_sram_wdata;
	logic [XLEN-1:0] inst_sram_rdata = '0;
	logic            data_sram_en;
	logic [3:0]      data_sram_wen;
	logic [XLEN-1:0] data_sram_addr;
	logic [XLEN-1:0] data_sram_wdata;
	logic [XLEN-1:0] data_sram_rdata = '0;
	logic [XLEN-1:0] debug_wb_pc;
	logic [3:0]      debug_wb_rf_wen;
	reg_addr_t       debug_wb_rf_wnum;
	logic [XLEN-1:0] debug_wb_rf_wdata;

	logic [XLEN-1:0] imem [256]; // 1 KB program window from RESET_PC
	logic [XLEN-1:0] dmem [256];
	logic [XLEN-1:0] gpr [32];   // reference register values
	retire_t         expected_q [$];
	int              prog_len;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	// instruction word returned one cycle after the address
	always @(posedge clk) begin
		if (inst_sram_en)
			inst_sram_rdata <= imem[inst_sram_addr[9:2]];
	end

	// data port, word writes land in the array at the edge
	always @(posedge clk) begin
		if (data_sram_en) begin
			if (data_sram_wen != 4'h0)
				dmem[data_sram_addr[9:2]] <= data_sram_wdata;
			data_sram_rdata <= dmem[data_sram_addr[9:2]];
		end
	end

	mips_core #(
		.RESET_PC (RESET_PC)
	) i_dut (
		.clk               (clk),
		.rst               (rst),
		.inst_sram_en      (inst_sram_en),
		.inst_sram_wen     (inst_sram_wen),
		.inst_sram_addr    (inst_sram_addr),
		.inst_sram_wdata   (inst_sram_wdata),
		.inst_sram_rdata   (inst_sram_rdata),
		.data_sram_en      (data_sram_en),
		.data_sram_wen     (data_sram_wen),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.data_sram_rdata   (data_sram_rdata),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "simulation stopped after the first error");
	endtask

	`include "tb_tasks.svh"

	// generous bound, each instruction gets 20 cycles
	initial begin
		repeat (TOTAL_INSTR * CYCLES_PER_INSTR) @(posedge clk);
		abort_run($sformatf("Timeout: tests did not finish within %0d cycles",
			TOTAL_INSTR * CYCLES_PER_INSTR));
	end

	initial begin
		rst = 1'b1;
		void'($urandom(32'h9f43)); // one seed for the whole run
		test_alu();
		test_forwarding();
		test_memory();
		test_branches();
		test_jumps();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: src.f
+incdir+verif
common/mips_pkg.sv
rtl/regfile.sv
rtl/alu.sv
core/decode_stage.sv
core/execute_stage.sv
core/result_stage.sv
core/mips_core.sv
verif/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - common/mips_pkg.sv
  - rtl/regfile.sv
  - rtl/alu.sv
  - core/decode_stage.sv
  - core/execute_stage.sv
  - core/result_stage.sv
  - core/mips_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_mips_core.sv
